// ==== common/alu_types_pkg.sv ====
//########################################
// Data word is fixed at 16 bits. Reserved
// status bits always read as zero.
//########################################
package alu_types_pkg;

  // One machine word on every data path of the slice.
  typedef logic [15:0] alu_word_t;

  // Flags produced by the function unit in the current cycle.
  // They are combinational and follow F directly.
  typedef struct packed {
    logic cry;  // Adder carry out.
    logic ovf;  // Signed overflow.
    logic zf;   // F is all zeros.
    logic sgr;  // Sign of F.
  } alu_flags_t;

  // Status register layout, bit 15 down to bit 0.
  // The flag nibble sits in the low four bits and the interrupt level in 11:8.
  typedef struct packed {
    logic       ioni;   // Interrupt system on in bit 15.
    logic       poni;   // Paging on in bit 14.
    logic [1:0] rsvd_hi;
    logic [3:0] pil;    // Current program interrupt level.
    logic [3:0] rsvd_lo;
    logic       c;      // Stored carry.
    logic       o;      // Stored overflow.
    logic       z;      // Stored zero.
    logic       m;      // Stored sign.
  } alu_sts_t;

endpackage

// ==== common/alu_micro_pkg.sv ====
//########################################
// Field codes of the ALU microinstruction.
//########################################
package alu_micro_pkg;

  // Function codes. Subtraction is done as R plus the complement of S.
  typedef enum logic [2:0] {
    func_add    = 3'd0,
    func_sub    = 3'd1,  // R minus S.
    func_subr   = 3'd2,  // S minus R.
    func_and    = 3'd3,
    func_or     = 3'd4,
    func_xor    = 3'd5,
    func_pass_r = 3'd6,
    func_pass_s = 3'd7
  } alu_func_e;

  // R operand source.
  typedef enum logic {r_sel_a = 1'b0, r_sel_dbr = 1'b1} r_sel_e;

  // S operand source.
  typedef enum logic [1:0] {s_sel_a, s_sel_b, s_sel_q, s_sel_zero} s_sel_e;

  // Carry-in source. Code 3 is unused and gives a zero carry.
  typedef enum logic [1:0] {cin_zero, cin_one, cin_sts_c} cin_sel_e;

  // Shift operation applied to F on its way to RB.
  typedef enum logic [1:0] {shift_none, shift_left, shift_right, shift_rotate_c} shift_e;

  // Internal data bus sources, in the order of the selector code.
  typedef enum logic [2:0] {
    idb_f, idb_rb, idb_sts, idb_gpr, idb_dbr, idb_q, idb_ea, idb_fidbi
  } idb_src_e;

  // One microinstruction word as seen by the slice.
  typedef struct packed {
    alu_func_e func;
    r_sel_e    r_sel;
    s_sel_e    s_sel;
    cin_sel_e  cin_sel;
    shift_e    shift;
    idb_src_e  idb_src;
    logic      q_load;  // Load Q from F at the next edge.
  } alu_micro_t;

endpackage

// ==== alu/alu_arith.sv ====
//########################################
// Purely combinational. Carry and overflow
// are zero for logic and pass functions.
//########################################
`timescale 1ns/1ps

module alu_arith
  import alu_types_pkg::*, alu_micro_pkg::*;
(
  input  alu_func_e  func,
  input  r_sel_e     r_sel,
  input  s_sel_e     s_sel,
  input  cin_sel_e   cin_sel,
  input  alu_word_t  a,
  input  alu_word_t  b,
  input  alu_word_t  dbr,
  input  alu_word_t  q,
  input  logic       sts_c,
  output alu_word_t  f,
  output alu_flags_t flags
);

  alu_word_t   r_op;
  alu_word_t   s_op;
  alu_word_t   add_x;
  alu_word_t   add_y;
  logic        cin;
  logic        is_arith;
  logic [16:0] sum;

  // The R operand comes either from the A bus or from the data buffer.
  assign r_op = (r_sel == r_sel_dbr) ? dbr : a;

  // The S operand can also be forced to zero, which turns add into increment.
  always_comb begin
    case (s_sel)
      s_sel_a: s_op = a;
      s_sel_b: s_op = b;
      s_sel_q: s_op = q;
      default: s_op = '0;
    endcase
  end

  // Carry-in source. The unused code behaves as zero.
  always_comb begin
    case (cin_sel)
      cin_one:   cin = 1'b1;
      cin_sts_c: cin = sts_c;
      default:   cin = 1'b0;
    endcase
  end

  // One adder serves add, sub and subr; the subtrahend is complemented.
  always_comb begin
    add_x    = r_op;
    add_y    = s_op;
    is_arith = 1'b1;
    case (func)
      func_add: add_y = s_op;
      func_sub: add_y = ~s_op;
      func_subr: begin
        add_x = s_op;
        add_y = ~r_op;
      end
      default: is_arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {16'd0, cin};

  // Result select. Arithmetic codes take the adder sum.
  always_comb begin
    case (func)
      func_and:    f = r_op & s_op;
      func_or:     f = r_op | s_op;
      func_xor:    f = r_op ^ s_op;
      func_pass_r: f = r_op;
      func_pass_s: f = s_op;
      default:     f = sum[15:0];
    endcase
  end

  // Overflow when both adder inputs share a sign that the sum does not.
  assign flags = '{
    cry: is_arith & sum[16],
    ovf: is_arith & (add_x[15] ~^ add_y[15]) & (sum[15] ^ add_x[15]),
    zf:  (f == 16'd0),
    sgr: f[15]
  };

endmodule

// ==== alu/alu_shift.sv ====
//########################################
// Combinational. Shifted-out bits are lost.
//########################################
`timescale 1ns/1ps

module alu_shift
  import alu_types_pkg::*, alu_micro_pkg::*;
(
  input  shift_e    shift,
  input  alu_word_t f,
  input  logic      sts_c,
  output alu_word_t rb
);

  // The link input at each end depends on the shift kind.
  // A left shift brings in zero at bit 0.
  // An arithmetic right shift repeats the sign bit.
  // A rotate brings the stored carry in at bit 15.
  always_comb begin
    case (shift)
      shift_left:     rb = {f[14:0], 1'b0};
      shift_right:    rb = {f[15], f[15:1]};
      shift_rotate_c: rb = {sts_c, f[15:1]};
      default:        rb = f;
    endcase
  end

endmodule

// ==== hw/alu_regs.sv ====
//########################################
// Loads take effect at the strobed edge.
//########################################
`timescale 1ns/1ps

module alu_regs
  import alu_types_pkg::*;
(
  input  logic      aluclk,
  input  logic      reset,
  input  logic      ld_gpr,
  input  logic      ld_dbr,
  input  logic      q_load,
  input  alu_word_t cd,
  input  alu_word_t f,
  output alu_word_t gpr,
  output alu_word_t dbr,
  output alu_word_t q
);

  // The general register is filled from the CD bus.
  always_ff @(posedge aluclk) begin
    if (reset) begin
      gpr <= '0;
    end else if (ld_gpr) begin
      gpr <= cd;
    end
  end

  // The data buffer also loads from CD, usually with memory read data.
  always_ff @(posedge aluclk) begin
    if (reset) begin
      dbr <= '0;
    end else if (ld_dbr) begin
      dbr <= cd;
    end
  end

  // Q holds a function result so it can serve as the S operand later.
  // The load bit comes straight from the microinstruction.
  always_ff @(posedge aluclk) begin
    if (reset) begin
      q <= '0;
    end else if (q_load) begin
      q <= f;
    end
  end

endmodule

// ==== hw/alu_status.sv ====
//########################################
// ioni and poni are held at zero here.
//########################################
`timescale 1ns/1ps

module alu_status
  import alu_types_pkg::*;
(
  input  logic       aluclk,
  input  logic       reset,
  input  logic       lcz,
  input  logic       ld_pil,
  input  alu_flags_t flags,
  input  alu_word_t  fidbo,
  output alu_sts_t   sts
);

  // The flag nibble and the interrupt level are independent fields.
  // Both can load in the same cycle when both strobes are set.
  always_ff @(posedge aluclk) begin
    if (reset) begin
      sts <= '0;
    end else begin
      // Arithmetic flags are captured from the function unit.
      if (lcz) begin
        sts.c <= flags.cry;
        sts.o <= flags.ovf;
        sts.z <= flags.zf;
        sts.m <= flags.sgr;
      end
      // The interrupt level arrives over the internal bus.
      if (ld_pil) begin
        sts.pil <= fidbo[11:8];
      end
      // Mode bits and reserved bits are never written in this slice.
      sts.ioni    <= 1'b0;
      sts.poni    <= 1'b0;
      sts.rsvd_hi <= 2'b00;
      sts.rsvd_lo <= 4'b0000;
    end
  end

endmodule

// ==== hw/alu_outmux.sv ====
//########################################
// Combinational bus source select. fidbo
// is not inverted in this slice.
//########################################
`timescale 1ns/1ps

module alu_outmux
  import alu_types_pkg::*, alu_micro_pkg::*;
(
  input  idb_src_e  idb_src,
  input  alu_word_t f,
  input  alu_word_t rb,
  input  alu_word_t gpr,
  input  alu_word_t dbr,
  input  alu_word_t q,
  input  alu_word_t ea,
  input  alu_word_t fidbi,
  input  alu_sts_t  sts,
  output alu_word_t fidbo
);

  // All results leave the slice through this selector.
  // The status register is placed on the bus as a plain word.
  // ea and fidbi pass through so the bus can carry outside values.
  always_comb begin
    case (idb_src)
      idb_f:     fidbo = f;
      idb_rb:    fidbo = rb;
      idb_sts:   fidbo = sts;
      idb_gpr:   fidbo = gpr;
      idb_dbr:   fidbo = dbr;
      idb_q:     fidbo = q;
      idb_ea:    fidbo = ea;
      default:   fidbo = fidbi;
    endcase
  end

endmodule

// ==== hw/alu_slice.sv ====
//########################################
// f, rb, flags and fidbo are combinational
// from inputs. Strobes act at the next edge.
//########################################
`timescale 1ns/1ps

module alu_slice
  import alu_types_pkg::*, alu_micro_pkg::*;
(
  input  logic       aluclk,
  input  logic       reset,
  input  alu_micro_t micro,
  input  alu_word_t  a,
  input  alu_word_t  b,
  input  alu_word_t  cd,
  input  alu_word_t  ea,
  input  alu_word_t  fidbi,
  input  logic       ld_gpr,
  input  logic       ld_dbr,
  input  logic       lcz,
  input  logic       ld_pil,
  output alu_word_t  f,
  output alu_word_t  rb,
  output alu_word_t  fidbo,
  output alu_flags_t flags,
  output alu_sts_t   sts
);

  // Register contents fed back into the operand and bus selectors.
  alu_word_t gpr;
  alu_word_t dbr;
  alu_word_t q;

  // Function unit with its operand selectors.
  alu_arith alu_arith_inst (
    .func    (micro.func),
    .r_sel   (micro.r_sel),
    .s_sel   (micro.s_sel),
    .cin_sel (micro.cin_sel),
    .a       (a),
    .b       (b),
    .dbr     (dbr),
    .q       (q),
    .sts_c   (sts.c),
    .f       (f),
    .flags   (flags)
  );

  // The rotate link uses the stored carry, not the current adder carry.
  alu_shift alu_shift_inst (
    .shift (micro.shift),
    .f     (f),
    .sts_c (sts.c),
    .rb    (rb)
  );

  alu_regs alu_regs_inst (
    .aluclk (aluclk),
    .reset  (reset),
    .ld_gpr (ld_gpr),
    .ld_dbr (ld_dbr),
    .q_load (micro.q_load),
    .cd     (cd),
    .f      (f),
    .gpr    (gpr),
    .dbr    (dbr),
    .q      (q)
  );

  // PIL is loaded from the bus output, so the microword picks its source.
  alu_status alu_status_inst (
    .aluclk (aluclk),
    .reset  (reset),
    .lcz    (lcz),
    .ld_pil (ld_pil),
    .flags  (flags),
    .fidbo  (fidbo),
    .sts    (sts)
  );

  alu_outmux alu_outmux_inst (
    .idb_src (micro.idb_src),
    .f       (f),
    .rb      (rb),
    .gpr     (gpr),
    .dbr     (dbr),
    .q       (q),
    .ea      (ea),
    .fidbi   (fidbi),
    .sts     (sts),
    .fidbo   (fidbo)
  );

endmodule

// ==== testbench/tb_alu_slice.sv ====
//########################################
// Directed and LFSR tests. The model tracks
// Q, GPR, DBR and status across cycles.
//########################################
`timescale 1ns/1ps

module tb_alu_slice
  import alu_types_pkg::*, alu_micro_pkg::*;
;

  // Cycle budget of each test. The watchdog is sized from these.
  localparam int reset_cycles = 5 + 4;
  localparam int func_cycles  = 72;
  localparam int shift_cycles = 26;
  localparam int misc_cycles  = 10 + 9;
  localparam int rand_cycles  = 200;
  localparam int total_cycles = reset_cycles + func_cycles + shift_cycles
                                + misc_cycles + rand_cycles;
  localparam int watchdog_ns  = total_cycles * 100 * 5 / 4;

  logic       aluclk;
  logic       reset;
  alu_micro_t micro;
  alu_word_t  a, b, cd, ea, fidbi;
  logic       ld_gpr, ld_dbr, lcz, ld_pil;
  alu_word_t  f, rb, fidbo;
  alu_flags_t flags;
  alu_sts_t   sts;

  // Model state is updated at each edge where its strobe was set.
  alu_sts_t    exp_sts;
  alu_word_t   exp_q, exp_gpr, exp_dbr;
  logic [31:0] lfsr_state = 32'h36bebf0b;

  alu_slice alu_slice_inst (
    .aluclk (aluclk), .reset (reset), .micro (micro),
    .a (a), .b (b), .cd (cd), .ea (ea), .fidbi (fidbi),
    .ld_gpr (ld_gpr), .ld_dbr (ld_dbr), .lcz (lcz), .ld_pil (ld_pil),
    .f (f), .rb (rb), .fidbo (fidbo), .flags (flags), .sts (sts)
  );

  initial begin
    aluclk = 1'b0;
    forever #50 aluclk = ~aluclk;
  end

  task automatic stop_on_failure();
    $display("Errors found");
    $fatal(1, "Simulation stopped.");
  endtask

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not reach the end in the expected time.");
    stop_on_failure();
  end

  task automatic check_word(input string name, input alu_word_t got, input alu_word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flags(input string name, input alu_flags_t got, input alu_flags_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_sts(input string name, input alu_sts_t got, input alu_sts_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // Galois LFSR that steps once for each bit handed out.
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'hD000_0001;
    return out;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[14:0], lfsr_step()};
    return v;
  endfunction

  // Reference function unit. Overflow is found by checking whether the
  // true signed result fits in 16 bits; subtraction adds the one's complement.
  function automatic void predict_alu(input alu_func_e fn, input alu_word_t r,
                                      input alu_word_t s, input logic cin,
                                      output alu_word_t res, output alu_flags_t fl);
    logic [16:0] wide;
    int          rs, ss, ci, sval;
    logic        arith;
    rs    = 32'($signed(r));
    ss    = 32'($signed(s));
    ci    = int'(cin);
    arith = 1'b1;
    wide  = '0;
    sval  = 0;
    res   = '0;
    case (fn)
      func_add: begin
        wide = {1'b0, r} + {1'b0, s} + 17'(cin);
        sval = rs + ss + ci;
      end
      func_sub: begin
        wide = {1'b0, r} + {1'b0, ~s} + 17'(cin);
        sval = rs - ss - 1 + ci;
      end
      func_subr: begin
        wide = {1'b0, s} + {1'b0, ~r} + 17'(cin);
        sval = ss - rs - 1 + ci;
      end
      func_and:    res = r & s;
      func_or:     res = r | s;
      func_xor:    res = r ^ s;
      func_pass_r: res = r;
      default:     res = s;
    endcase
    if (fn inside {func_add, func_sub, func_subr}) res = wide[15:0];
    else arith = 1'b0;
    fl.cry = arith & wide[16];
    fl.ovf = arith & ((sval > 32767) || (sval < -32768));
    fl.zf  = (res == 16'h0000);
    fl.sgr = res[15];
  endfunction

  function automatic alu_word_t shift_word(input shift_e sh, input alu_word_t x,
                                           input logic c);
    case (sh)
      shift_left:     return x << 1;
      shift_right:    return alu_word_t'($signed(x) >>> 1);
      shift_rotate_c: return {c, x[15:1]};
      default:        return x;
    endcase
  endfunction

  // Sets the microword and drops all strobes; tests raise strobes afterwards.
  task automatic drive(input alu_func_e fn, input r_sel_e rs, input s_sel_e ss,
                       input cin_sel_e cs, input shift_e sh, input idb_src_e src);
    micro = '{func: fn, r_sel: rs, s_sel: ss, cin_sel: cs, shift: sh,
              idb_src: src, q_load: 1'b0};
    ld_gpr = 1'b0;
    ld_dbr = 1'b0;
    lcz    = 1'b0;
    ld_pil = 1'b0;
  endtask

  // Checks all outputs at the falling edge, then advances the model
  // and moves to 10 ns after the next rising edge.
  task automatic run_cycle();
    alu_word_t  r_exp, s_exp, f_exp, rb_exp, bus_exp;
    alu_flags_t fl_exp;
    logic       cin_exp;
    r_exp = (micro.r_sel == r_sel_dbr) ? exp_dbr : a;
    case (micro.s_sel)
      s_sel_a: s_exp = a;
      s_sel_b: s_exp = b;
      s_sel_q: s_exp = exp_q;
      default: s_exp = '0;
    endcase
    cin_exp = (micro.cin_sel == cin_one) ||
              ((micro.cin_sel == cin_sts_c) && exp_sts.c);
    predict_alu(micro.func, r_exp, s_exp, cin_exp, f_exp, fl_exp);
    rb_exp = shift_word(micro.shift, f_exp, exp_sts.c);
    case (micro.idb_src)
      idb_f:   bus_exp = f_exp;
      idb_rb:  bus_exp = rb_exp;
      idb_sts: bus_exp = exp_sts;
      idb_gpr: bus_exp = exp_gpr;
      idb_dbr: bus_exp = exp_dbr;
      idb_q:   bus_exp = exp_q;
      idb_ea:  bus_exp = ea;
      default: bus_exp = fidbi;
    endcase
    @(negedge aluclk);
    check_word("f", f, f_exp);
    check_flags("flags", flags, fl_exp);
    check_word("rb", rb, rb_exp);
    check_word("fidbo", fidbo, bus_exp);
    check_sts("sts", sts, exp_sts);
    if (lcz) {exp_sts.c, exp_sts.o, exp_sts.z, exp_sts.m} = fl_exp;
    if (ld_pil) exp_sts.pil = bus_exp[11:8];
    if (micro.q_load) exp_q = f_exp;
    if (ld_gpr) exp_gpr = cd;
    if (ld_dbr) exp_dbr = cd;
    @(posedge aluclk);
    #10;
  endtask

  task automatic test_reset();
    idb_src_e srcs [4] = '{idb_sts, idb_q, idb_gpr, idb_dbr};
    for (int i = 0; i < 4; i++) begin
      drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, srcs[i]);
      run_cycle();
    end
  endtask

  // Operands chosen so that add, sub and subr cross the sign boundary.
  task automatic test_functions();
    s_sel_e s_list [3] = '{s_sel_a, s_sel_b, s_sel_zero};
    a = 16'h7f3c;
    b = 16'h80c5;
    for (int fn = 0; fn < 8; fn++) begin
      for (int cs = 0; cs < 3; cs++) begin
        for (int si = 0; si < 3; si++) begin
          drive(alu_func_e'(3'(fn)), r_sel_a, s_list[si], cin_sel_e'(2'(cs)),
                shift_none, idb_f);
          run_cycle();
        end
      end
    end
  endtask

  // ffff plus zero plus the carry-in leaves a carry exactly when cin is one.
  task automatic set_carry(input logic c);
    a = 16'hffff;
    b = 16'h0000;
    drive(func_add, r_sel_a, s_sel_b, c ? cin_one : cin_zero, shift_none, idb_f);
    lcz = 1'b1;
    run_cycle();
  endtask

  task automatic test_shift();
    alu_word_t vals [3] = '{16'h8001, 16'h4ace, 16'hffff};
    for (int c = 1; c >= 0; c--) begin
      set_carry(1'(c));
      for (int v = 0; v < 3; v++) begin
        for (int sh = 0; sh < 4; sh++) begin
          a = vals[v];
          drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_e'(2'(sh)), idb_rb);
          run_cycle();
        end
      end
    end
  endtask

  task automatic test_registers();
    cd = 16'h1234;
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_f);
    ld_gpr = 1'b1;
    run_cycle();
    cd = 16'habcd;
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_f);
    ld_dbr = 1'b1;
    run_cycle();
    a = 16'h5a5a;
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_f);
    micro.q_load = 1'b1;
    run_cycle();
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_gpr);
    run_cycle();
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_dbr);
    run_cycle();
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_q);
    run_cycle();
    // DBR on R and Q on S feed the function unit.
    drive(func_add, r_sel_dbr, s_sel_q, cin_zero, shift_none, idb_f);
    run_cycle();
    drive(func_xor, r_sel_dbr, s_sel_q, cin_zero, shift_none, idb_f);
    run_cycle();
    ea    = 16'hc3e1;
    fidbi = 16'h0f1e;
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_ea);
    run_cycle();
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_fidbi);
    run_cycle();
  endtask

  task automatic test_status();
    alu_word_t pil_words [3] = '{16'h0a00, 16'hf5ff, 16'h0300};
    // 8000 plus 8000 gives zero with carry and overflow.
    a = 16'h8000;
    b = 16'h8000;
    drive(func_add, r_sel_a, s_sel_b, cin_zero, shift_none, idb_sts);
    lcz = 1'b1;
    run_cycle();
    drive(func_pass_r, r_sel_a, s_sel_zero, cin_zero, shift_none, idb_sts);
    run_cycle();
    a = 16'h7fff;
    b = 16'h0001;
    drive(func_add, r_sel_a, s_sel_b, cin_zero, shift_none, idb_f);
    lcz = 1'b1;
    run_cycle();
    for (int i = 0; i < 3; i++) begin
      fidbi = pil_words[i];
      drive(func_sub, r_sel_a, s_sel_b, cin_one, shift_none, idb_fidbi);
      ld_pil = 1'b1;
      lcz    = (i == 2);
      run_cycle();
    end
    // No strobes here, so sts must hold.
    for (int i = 0; i < 3; i++) begin
      a = 16'h0f0f << i;
      drive(func_or, r_sel_a, s_sel_b, cin_one, shift_none, idb_sts);
      run_cycle();
    end
  endtask

  task automatic test_random();
    alu_func_e fn;
    r_sel_e    rs;
    s_sel_e    ss;
    cin_sel_e  cs;
    shift_e    sh;
    idb_src_e  src;
    for (int n = 0; n < rand_cycles; n++) begin
      a   = rand_bits(16);
      b   = rand_bits(16);
      fn  = alu_func_e'(3'(rand_bits(3)));
      rs  = r_sel_e'(1'(rand_bits(1)));
      ss  = s_sel_e'(2'(rand_bits(2)));
      cs  = cin_sel_e'(2'(rand_bits(2)));
      sh  = shift_e'(2'(rand_bits(2)));
      src = idb_src_e'(3'(rand_bits(3)));
      drive(fn, rs, ss, cs, sh, src);
      micro.q_load = 1'(rand_bits(1));
      lcz          = 1'(rand_bits(1));
      run_cycle();
    end
  endtask

  initial begin
    micro  = '0;
    a      = '0;
    b      = '0;
    cd     = '0;
    ea     = '0;
    fidbi  = '0;
    ld_gpr = 1'b0;
    ld_dbr = 1'b0;
    lcz    = 1'b0;
    ld_pil = 1'b0;
    reset  = 1'b1;
    exp_sts = '0;
    exp_q   = '0;
    exp_gpr = '0;
    exp_dbr = '0;
    repeat (5) @(posedge aluclk);
    #10;
    reset = 1'b0;
    test_reset();
    test_functions();
    test_shift();
    test_registers();
    test_status();
    test_random();
    $display("No errors");
    $finish;
  end

endmodule

// ==== alu_slice.f ====
common/alu_types_pkg.sv
common/alu_micro_pkg.sv
alu/alu_arith.sv
alu/alu_shift.sv
hw/alu_regs.sv
hw/alu_status.sv
hw/alu_outmux.sv
hw/alu_slice.sv
testbench/tb_alu_slice.sv

// ==== Makefile ====
# Verilator build and run for the ALU slice testbench.
VERILATOR ?= verilator
TOP       ?= tb_alu_slice
FILELIST  ?= alu_slice.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass message shows up in the output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
